/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and judge the log
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module accel_tb -f sim.f -o accel_sim \
	&& ./obj_dir/accel_sim 2>&1 | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } \
	|| echo "simulation passed"

/* sim.f */
verilog/accel_pkg.sv
verilog/layer_if.sv
verilog/stream_fifo.sv
verilog/block_throttle.sv
verilog/cmd_decoder.sv
verilog/dot_engine.sv
verilog/accel_top.sv
sim/clk_gen.sv
sim/accel_props.sv
sim/accel_tb.sv

/* sim/accel_props.sv */
`timescale 1ns/1ps

module accel_props (
	input logic okClk,
	input logic i_rst_n,
	input logic i_data_valid,
	input logic i_weig_valid,
	input logic i_data_rd,
	input logic i_weig_rd,
	input logic i_res_we,
	input logic i_res_full,
	input logic i_busy,
	input logic i_done
);

	// ------------------------------------------------------------
	// engine handshake rules
	// ------------------------------------------------------------
	a_no_pop_empty: assert property (@(posedge okClk) disable iff (!i_rst_n)
		(i_data_rd || i_weig_rd) |-> (i_data_valid && i_weig_valid))
		else $error("operand pair popped while a FIFO is empty");

	a_no_write_full: assert property (@(posedge okClk) disable iff (!i_rst_n)
		i_res_we |-> !i_res_full)
		else $error("result written while the result FIFO is full");

	a_done_after_busy: assert property (@(posedge okClk) disable iff (!i_rst_n)
		i_done |-> (i_busy && $past(i_busy)))
		else $error("done pulse without a busy layer before it");

endmodule

bind dot_engine accel_props props0 (
	.okClk(okClk), .i_rst_n(i_rst_n),
	.i_data_valid(i_data_valid), .i_weig_valid(i_weig_valid),
	.i_data_rd(o_data_rd), .i_weig_rd(o_weig_rd),
	.i_res_we(o_res_we), .i_res_full(i_res_full),
	.i_busy(o_busy), .i_done(o_done));

/* sim/accel_tb.sv */
`timescale 1ns/1ps

module accel_tb;

	import accel_pkg::*;

	localparam int DEPTH    = 64;
	localparam int BLOCK    = 16;
	localparam int HEADROOM = 4;
	localparam int LIMIT    = DEPTH - HEADROOM - BLOCK;  // highest count with ready
	localparam int TIMEOUT  = 2000;                      // cycles per wait

	logic       okClk;
	logic       i_rst_n;
	logic       i_cmd_we;
	logic       i_data_we;
	logic       i_weig_we;
	word_t      i_cmd_data;
	word_t      i_data_data;
	word_t      i_weig_data;
	logic       o_cmd_ready;
	logic       o_data_ready;
	logic       o_weig_ready;
	logic       i_res_re;
	logic       o_res_valid;
	word_t      o_res_data;
	logic       o_busy;
	logic       o_done;
	logic [7:0] o_bad_cmd_count;

	integer seed         = 24726;
	int     value_errors = 0;
	int     wait_errors  = 0;
	bit     aborted      = 1'b0;
	int     done_count   = 0;
	word_t  pend_cmd[$];   // host words not yet sent
	word_t  pend_data[$];
	word_t  pend_weig[$];
	word_t  exp_q[$];      // expected results in order

	clk_gen clk0 (.okClk(okClk), .o_rst_n(i_rst_n));

	accel_top #(.DEPTH(DEPTH), .BLOCK(BLOCK), .HEADROOM(HEADROOM)) dut0 (.*);

	always @(negedge okClk) begin
		if (i_rst_n && o_done)
			done_count <= done_count + 1;
	end

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			value_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t: %s", $time, what);
		wait_errors++;
		aborted = 1'b1;
	endtask

	function automatic word_t cmd_word0(input logic [2:0] op, input logic [15:0] len);
		return {8'h00, len, 5'h00, op};  // op in [2:0], length in [23:8]
	endfunction

	// operands and expected result for one layer; mode +1 or -1 fixes the sign
	task automatic make_layer(input logic [2:0] op, input int n, input int mode);
		word_t rd;
		word_t rw;
		elem_t d;
		elem_t w;
		acc_t  bias;
		acc_t  sum;
		int    i;
		bias = $random(seed);
		if (mode != 0)
			bias = mode * (bias & 32'hff);
		sum = bias;
		pend_cmd.push_back(cmd_word0(op, n[15:0]));
		pend_cmd.push_back(word_t'(bias));
		for (i = 0; i < n; i++) begin
			rd = $random(seed);  // upper half is noise
			rw = $random(seed);
			if (mode != 0) begin
				rd[15:0] = {8'h00, rd[7:0] | 8'h01};
				rw[15:0] = {8'h00, rw[7:0] | 8'h01};
				if (mode < 0)
					rw[15:0] = -rw[15:0];
			end
			d = elem_t'(rd[15:0]);
			w = elem_t'(rw[15:0]);
			sum = sum + acc_t'(d) * acc_t'(w);  // 32-bit wrap
			pend_data.push_back(rd);
			pend_weig.push_back(rw);
		end
		if ((op == OP_MAC_RELU) && (sum < 0))
			exp_q.push_back('0);
		else
			exp_q.push_back(word_t'(sum));
	endtask

	// ------------------------------------------------------------
	// host side
	// ------------------------------------------------------------
	task automatic wait_ready(input logic need_cmd, input logic need_data,
		input logic need_weig);
		int t;
		t = 0;
		@(posedge okClk);
		i_cmd_we  <= 1'b0;
		i_data_we <= 1'b0;
		i_weig_we <= 1'b0;
		@(negedge okClk);
		while (!aborted && (t < TIMEOUT) && ((need_cmd && !o_cmd_ready) ||
			(need_data && !o_data_ready) || (need_weig && !o_weig_ready))) begin
			@(negedge okClk);
			t++;
		end
		if (t >= TIMEOUT)
			report_timeout("input FIFO ready flag stayed low");
	endtask

	task automatic send_layers();
		int n;
		n = 0;
		while (!aborted && (pend_cmd.size() > 0)) begin
			if (n % BLOCK == 0)
				wait_ready(1'b1, 1'b0, 1'b0);  // one block at a time
			@(posedge okClk);
			i_cmd_we   <= 1'b1;
			i_cmd_data <= pend_cmd.pop_front();
			n++;
		end
		n = 0;
		while (!aborted && ((pend_data.size() > 0) || (pend_weig.size() > 0))) begin
			if (n % BLOCK == 0)
				wait_ready(1'b0, pend_data.size() > 0, pend_weig.size() > 0);
			@(posedge okClk);
			i_data_we <= (pend_data.size() > 0);
			i_weig_we <= (pend_weig.size() > 0);
			if (pend_data.size() > 0)
				i_data_data <= pend_data.pop_front();
			if (pend_weig.size() > 0)
				i_weig_data <= pend_weig.pop_front();
			n++;
		end
		@(posedge okClk);
		i_cmd_we  <= 1'b0;
		i_data_we <= 1'b0;
		i_weig_we <= 1'b0;
	endtask

	task automatic wait_done_count(input int target);
		int t;
		t = 0;
		while (!aborted && (done_count < target) && (t < TIMEOUT)) begin
			@(negedge okClk);
			t++;
		end
		if (!aborted && (done_count < target))
			report_timeout("o_done never pulsed for a queued layer");
	endtask

	task automatic pop_result();
		int t;
		t = 0;
		@(negedge okClk);
		while (!aborted && !o_res_valid && (t < TIMEOUT)) begin
			@(negedge okClk);
			t++;
		end
		if (aborted)
			return;
		if (!o_res_valid) begin
			report_timeout("result FIFO stayed empty");
			return;
		end
		check_word("o_res_data", o_res_data, exp_q.pop_front());
		@(posedge okClk);
		i_res_re <= 1'b1;
		@(posedge okClk);
		i_res_re <= 1'b0;
	endtask

	task automatic drain_results();
		while (!aborted && (exp_q.size() > 0))
			pop_result();
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic wait_reset();
		int t;
		t = 0;
		@(negedge okClk);
		while (!i_rst_n && (t < TIMEOUT)) begin
			@(negedge okClk);
			t++;
		end
		if (!i_rst_n) begin
			report_timeout("reset was never released");
			return;
		end
		check_flag("o_cmd_ready", o_cmd_ready, 1'b0);  // flags still at reset value
		check_flag("o_data_ready", o_data_ready, 1'b0);
		check_flag("o_weig_ready", o_weig_ready, 1'b0);
		check_flag("o_res_valid", o_res_valid, 1'b0);
		check_flag("o_busy", o_busy, 1'b0);
		check_flag("o_done", o_done, 1'b0);
		check_count("o_bad_cmd_count", o_bad_cmd_count, 8'd0);
	endtask

	task automatic test_basic_mac();
		int base;
		base = done_count;
		make_layer(OP_MAC, 8, 0);
		send_layers();
		wait_done_count(base + 1);
		drain_results();
	endtask

	task automatic test_relu();
		int base;
		base = done_count;
		make_layer(OP_MAC_RELU, 6, -1);  // clamps to zero
		make_layer(OP_MAC_RELU, 6, 1);
		send_layers();
		wait_done_count(base + 2);
		drain_results();
	endtask

	task automatic test_back_to_back();
		int base;
		base = done_count;
		make_layer(OP_MAC, 5, 0);
		make_layer(OP_MAC_RELU, 3, 0);
		make_layer(OP_MAC, 1, 0);
		make_layer(OP_MAC, 12, 0);
		send_layers();  // all commands go ahead of the data
		wait_done_count(base + 4);
		drain_results();
	endtask

	task automatic test_backpressure();
		int base;
		int i;
		base = done_count;
		for (i = 0; i < DEPTH + 2; i++) begin
			make_layer(OP_MAC, 2, 0);
			send_layers();
		end
		wait_done_count(base + DEPTH);  // result FIFO now full
		for (i = 0; i < 16; i++) begin
			@(negedge okClk);
			check_flag("o_busy", o_busy, 1'b1);
		end
		drain_results();
		wait_done_count(base + DEPTH + 2);
	endtask

	task automatic test_throttle();
		int base;
		int k;
		base = done_count;
		make_layer(OP_MAC, LIMIT + 2, 0);
		for (k = 1; k <= LIMIT + 2; k++) begin
			@(posedge okClk);
			i_data_we   <= 1'b1;
			i_data_data <= pend_data.pop_front();
			@(posedge okClk);
			i_data_we <= 1'b0;
			@(negedge okClk);
			@(negedge okClk);  // flag registered one cycle after the count
			check_flag("o_data_ready", o_data_ready, k <= LIMIT);
			check_flag("o_cmd_ready", o_cmd_ready, 1'b1);  // other FIFOs stay empty
			check_flag("o_weig_ready", o_weig_ready, 1'b1);
		end
		send_layers();
		wait_done_count(base + 1);
		drain_results();
	endtask

	task automatic test_bad_opcode();
		int base;
		base = done_count;
		pend_cmd.push_back(cmd_word0(3'd5, 16'd4));
		pend_cmd.push_back(32'h0000_1234);  // bias word of the bad command
		make_layer(OP_MAC, 4, 0);
		send_layers();
		wait_done_count(base + 1);
		check_count("o_bad_cmd_count", o_bad_cmd_count, 8'd1);
		drain_results();
		@(negedge okClk);
		check_flag("o_res_valid", o_res_valid, 1'b0);
		check_count("o_done pulses", 8'(done_count - base), 8'd1);
	endtask

	initial begin
		i_cmd_we    = 1'b0;
		i_data_we   = 1'b0;
		i_weig_we   = 1'b0;
		i_cmd_data  = '0;
		i_data_data = '0;
		i_weig_data = '0;
		i_res_re    = 1'b0;
		wait_reset();
		if (!aborted)
			test_basic_mac();
		if (!aborted)
			test_relu();
		if (!aborted)
			test_back_to_back();
		if (!aborted)
			test_backpressure();
		if (!aborted)
			test_throttle();
		if (!aborted)
			test_bad_opcode();
		$display("value errors: %0d, timeouts: %0d", value_errors, wait_errors);
		if ((value_errors == 0) && (wait_errors == 0))
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
	parameter int HALF_PERIOD = 20,  // 40 ns clock
	parameter int RST_CYCLES  = 5
) (
	output logic okClk,
	output logic o_rst_n
);

	initial begin
		okClk = 1'b0;
		forever #(HALF_PERIOD) okClk = ~okClk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge okClk);
		o_rst_n <= 1'b1;  // released on a rising edge
	end

endmodule

/* verilog/accel_pkg.sv */
package accel_pkg;

	// ------------------------------------------------------------
	// payload types
	// ------------------------------------------------------------
	typedef logic        [31:0] word_t;  // host word
	typedef logic signed [15:0] elem_t;  // data and weight operand
	typedef logic signed [31:0] acc_t;   // wraps on overflow

	typedef enum logic [2:0] {
		OP_MAC      = 3'd1,  // plain dot product
		OP_MAC_RELU = 3'd2   // negative result clamps to zero
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [15:0] length;  // pairs, 0 means 1
		acc_t        bias;
	} layer_desc_t;

	// ------------------------------------------------------------
	// command word 0 layout
	// ------------------------------------------------------------
	localparam int CMD_OP_LSB  = 0;
	localparam int CMD_LEN_LSB = 8;

	function automatic logic op_valid(input logic [2:0] op_bits);
		return (op_bits == OP_MAC) || (op_bits == OP_MAC_RELU);
	endfunction

endpackage

/* verilog/accel_top.sv */
`timescale 1ns/1ps

module accel_top #(
	parameter int DEPTH    = 64,
	parameter int BLOCK    = 16,
	parameter int HEADROOM = 4
) (
	input  logic             okClk,
	input  logic             i_rst_n,
	input  logic             i_cmd_we,
	input  logic             i_data_we,
	input  logic             i_weig_we,
	input  accel_pkg::word_t i_cmd_data,
	input  accel_pkg::word_t i_data_data,
	input  accel_pkg::word_t i_weig_data,
	output logic             o_cmd_ready,
	output logic             o_data_ready,
	output logic             o_weig_ready,
	input  logic             i_res_re,
	output logic             o_res_valid,
	output accel_pkg::word_t o_res_data,
	output logic             o_busy,
	output logic             o_done,
	output logic [7:0]       o_bad_cmd_count
);

	import accel_pkg::*;

	localparam int CW = $clog2(DEPTH) + 1;

	word_t          cmd_word;
	logic           cmd_valid;
	logic           cmd_rd;
	logic [CW-1:0]  cmd_count;
	elem_t          data_wr;     // low half of host word
	elem_t          data_elem;
	logic           data_valid;
	logic           data_rd;
	logic [CW-1:0]  data_count;
	elem_t          weig_wr;
	elem_t          weig_elem;
	logic           weig_valid;
	logic           weig_rd;
	logic [CW-1:0]  weig_count;
	word_t          res_word;
	logic           res_we;
	logic           res_full;

	layer_if layer_bus ();

	assign data_wr = $signed(i_data_data[15:0]);
	assign weig_wr = $signed(i_weig_data[15:0]);

	// ------------------------------------------------------------
	// input FIFOs and throttle
	// ------------------------------------------------------------
	stream_fifo #(.T(word_t), .DEPTH(DEPTH)) cmd_fifo (
		.okClk(okClk), .i_rst_n(i_rst_n),
		.i_wr_en(i_cmd_we), .i_wr_data(i_cmd_data),
		.i_rd_en(cmd_rd), .o_rd_data(cmd_word), .o_rd_valid(cmd_valid),
		.o_full(), .o_count(cmd_count));

	stream_fifo #(.T(elem_t), .DEPTH(DEPTH)) data_fifo (
		.okClk(okClk), .i_rst_n(i_rst_n),
		.i_wr_en(i_data_we), .i_wr_data(data_wr),
		.i_rd_en(data_rd), .o_rd_data(data_elem), .o_rd_valid(data_valid),
		.o_full(), .o_count(data_count));

	stream_fifo #(.T(elem_t), .DEPTH(DEPTH)) weig_fifo (
		.okClk(okClk), .i_rst_n(i_rst_n),
		.i_wr_en(i_weig_we), .i_wr_data(weig_wr),
		.i_rd_en(weig_rd), .o_rd_data(weig_elem), .o_rd_valid(weig_valid),
		.o_full(), .o_count(weig_count));

	block_throttle #(.DEPTH(DEPTH), .BLOCK(BLOCK), .HEADROOM(HEADROOM)) throttle (
		.okClk(okClk), .i_rst_n(i_rst_n),
		.i_cmd_count(cmd_count), .i_data_count(data_count), .i_weig_count(weig_count),
		.o_cmd_ready(o_cmd_ready), .o_data_ready(o_data_ready),
		.o_weig_ready(o_weig_ready));

	// ------------------------------------------------------------
	// decode, compute, result
	// ------------------------------------------------------------
	cmd_decoder decoder (
		.okClk(okClk), .i_rst_n(i_rst_n),
		.i_cmd_word(cmd_word), .i_cmd_valid(cmd_valid), .o_cmd_rd(cmd_rd),
		.o_bad_cmd_count(o_bad_cmd_count), .desc_out(layer_bus));

	dot_engine engine (
		.okClk(okClk), .i_rst_n(i_rst_n), .desc_in(layer_bus),
		.i_data(data_elem), .i_data_valid(data_valid), .o_data_rd(data_rd),
		.i_weig(weig_elem), .i_weig_valid(weig_valid), .o_weig_rd(weig_rd),
		.o_res_we(res_we), .o_res_data(res_word), .i_res_full(res_full),
		.o_busy(o_busy), .o_done(o_done));

	stream_fifo #(.T(word_t), .DEPTH(DEPTH)) result_fifo (
		.okClk(okClk), .i_rst_n(i_rst_n),
		.i_wr_en(res_we), .i_wr_data(res_word),
		.i_rd_en(i_res_re), .o_rd_data(o_res_data), .o_rd_valid(o_res_valid),
		.o_full(res_full), .o_count());

endmodule

/* verilog/block_throttle.sv */
`timescale 1ns/1ps

module block_throttle #(
	parameter int DEPTH    = 64,
	parameter int BLOCK    = 16,
	parameter int HEADROOM = 4
) (
	input  logic                   okClk,
	input  logic                   i_rst_n,
	input  logic [$clog2(DEPTH):0] i_cmd_count,
	input  logic [$clog2(DEPTH):0] i_data_count,
	input  logic [$clog2(DEPTH):0] i_weig_count,
	output logic                   o_cmd_ready,
	output logic                   o_data_ready,
	output logic                   o_weig_ready
);

	localparam int CW = $clog2(DEPTH) + 1;
	// room for one more block, with margin for count latency
	localparam logic [CW-1:0] LIMIT = CW'(DEPTH - HEADROOM - BLOCK);

	always_ff @(posedge okClk) begin
		if (!i_rst_n) begin
			o_cmd_ready  <= 1'b0;
			o_data_ready <= 1'b0;
			o_weig_ready <= 1'b0;
		end else begin
			o_cmd_ready  <= (i_cmd_count <= LIMIT);
			o_data_ready <= (i_data_count <= LIMIT);
			o_weig_ready <= (i_weig_count <= LIMIT);
		end
	end

endmodule

/* verilog/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder (
	input  logic             okClk,
	input  logic             i_rst_n,
	input  accel_pkg::word_t i_cmd_word,
	input  logic             i_cmd_valid,
	output logic             o_cmd_rd,
	output logic [7:0]       o_bad_cmd_count,
	layer_if.src             desc_out
);

	import accel_pkg::*;

	typedef enum logic [1:0] {
		ST_WORD0,  // op and length
		ST_WORD1,  // bias
		ST_ISSUE   // descriptor offered to engine
	} state_e;

	state_e      state;
	layer_desc_t desc_q;
	logic        op_ok;  // opcode check from word 0

	assign o_cmd_rd            = i_cmd_valid && (state != ST_ISSUE);
	assign desc_out.desc_valid = (state == ST_ISSUE);
	assign desc_out.desc       = desc_q;

	// ------------------------------------------------------------
	// command FSM
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!i_rst_n) begin
			state           <= ST_WORD0;
			o_bad_cmd_count <= '0;
		end else begin
			case (state)
				ST_WORD0: begin
					if (o_cmd_rd)
						state <= ST_WORD1;
				end
				ST_WORD1: begin
					if (o_cmd_rd) begin
						if (op_ok) begin
							state <= ST_ISSUE;
						end else begin
							state <= ST_WORD0;  // bias word discarded
							if (o_bad_cmd_count != 8'hff)
								o_bad_cmd_count <= o_bad_cmd_count + 8'd1;
						end
					end
				end
				ST_ISSUE: begin
					if (desc_out.desc_ready)
						state <= ST_WORD0;
				end
				default: state <= ST_WORD0;
			endcase
		end
	end

	// field capture
	always_ff @(posedge okClk) begin
		if (o_cmd_rd && (state == ST_WORD0)) begin
			desc_q.op     <= op_e'(i_cmd_word[CMD_OP_LSB +: 3]);
			desc_q.length <= i_cmd_word[CMD_LEN_LSB +: 16];
			op_ok         <= op_valid(i_cmd_word[CMD_OP_LSB +: 3]);
		end
		if (o_cmd_rd && (state == ST_WORD1))
			desc_q.bias <= acc_t'(i_cmd_word);
	end

endmodule

/* verilog/dot_engine.sv */
`timescale 1ns/1ps

module dot_engine (
	input  logic             okClk,
	input  logic             i_rst_n,
	layer_if.snk             desc_in,
	input  accel_pkg::elem_t i_data,
	input  logic             i_data_valid,
	output logic             o_data_rd,
	input  accel_pkg::elem_t i_weig,
	input  logic             i_weig_valid,
	output logic             o_weig_rd,
	output logic             o_res_we,
	output accel_pkg::word_t o_res_data,
	input  logic             i_res_full,
	output logic             o_busy,
	output logic             o_done
);

	import accel_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,    // popping pairs
		ST_DRAIN,  // last product accumulates
		ST_WRITE   // waits for result FIFO room
	} state_e;

	state_e      state;
	logic [15:0] pairs_left;
	op_e         op_q;
	logic        take;
	logic        pop;
	acc_t        prod_q;
	logic        prod_v;
	acc_t        acc_q;

	assign desc_in.desc_ready = (state == ST_IDLE);
	assign take               = desc_in.desc_valid && desc_in.desc_ready;

	assign pop       = (state == ST_RUN) && i_data_valid && i_weig_valid;
	assign o_data_rd = pop;
	assign o_weig_rd = pop;

	assign o_res_we   = (state == ST_WRITE) && !i_res_full;
	assign o_res_data = ((op_q == OP_MAC_RELU) && acc_q[31]) ? '0 : word_t'(acc_q);
	assign o_busy     = (state != ST_IDLE);
	assign o_done     = o_res_we;  // one pulse per layer

	// ------------------------------------------------------------
	// layer control
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!i_rst_n) begin
			state      <= ST_IDLE;
			pairs_left <= '0;
			prod_v     <= 1'b0;
		end else begin
			prod_v <= pop;
			case (state)
				ST_IDLE: begin
					if (take) begin
						state      <= ST_RUN;
						pairs_left <= (desc_in.desc.length == '0) ? 16'd1 : desc_in.desc.length;
					end
				end
				ST_RUN: begin
					if (pop) begin
						pairs_left <= pairs_left - 16'd1;
						if (pairs_left == 16'd1)
							state <= ST_DRAIN;
					end
				end
				ST_DRAIN: state <= ST_WRITE;
				ST_WRITE: begin
					if (!i_res_full)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// multiply then accumulate
	always_ff @(posedge okClk) begin
		if (pop)
			prod_q <= i_data * i_weig;  // signed 16x16 into 32
		if (take) begin
			op_q  <= desc_in.desc.op;
			acc_q <= desc_in.desc.bias;  // seed with bias
		end else if (prod_v) begin
			acc_q <= acc_q + prod_q;
		end
	end

endmodule

/* verilog/layer_if.sv */
`timescale 1ns/1ps

interface layer_if;
	import accel_pkg::*;

	logic        desc_valid;  // held until accepted
	logic        desc_ready;  // engine idle
	layer_desc_t desc;

	modport src (
		output desc_valid,
		output desc,
		input  desc_ready
	);

	modport snk (
		input  desc_valid,
		input  desc,
		output desc_ready
	);

endinterface

/* verilog/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
	parameter type T     = accel_pkg::word_t,
	parameter int  DEPTH = 64
) (
	input  logic                   okClk,
	input  logic                   i_rst_n,
	input  logic                   i_wr_en,
	input  T                       i_wr_data,
	input  logic                   i_rd_en,
	output T                       o_rd_data,
	output logic                   o_rd_valid,
	output logic                   o_full,
	output logic [$clog2(DEPTH):0] o_count
);

	localparam int AW = $clog2(DEPTH);

	T            mem [DEPTH];
	logic [AW:0] wr_ptr;  // extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic        wr_ok;
	logic        rd_ok;

	assign o_count    = wr_ptr - rd_ptr;
	assign o_rd_valid = (o_count != '0);
	assign o_full     = o_count[AW];  // count has reached DEPTH
	assign o_rd_data  = mem[rd_ptr[AW-1:0]];  // show-ahead

	assign wr_ok = i_wr_en && !o_full;      // drop on full
	assign rd_ok = i_rd_en && o_rd_valid;   // ignore on empty

	// ------------------------------------------------------------
	// pointers
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge okClk) begin
		if (wr_ok)
			mem[wr_ptr[AW-1:0]] <= i_wr_data;
	end

endmodule
